// File: sources.f
+incdir+include
source/camCpiPkg.sv
source/cpiSampler.sv
source/cpiLineGate.sv
source/fbPacker.sv
source/fbRam.sv
source/mmioCamPort.sv
source/camCpiCapture.sv
tests/camCpiChecker.sv
tests/camCpiCaptureTb.sv

// File: tests/camCpiCaptureTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "camCpi_cfg.svh"

module camCpiCaptureTb
	import camCpiPkg::*;
();

	localparam int rows = 14;
	localparam int rowBytes = 128;
	localparam int rowFirst = 2;
	localparam int rowLast = 9;
	localparam int keptWords = 8;
	localparam int driveDelay = 10;
	localparam int rowCycles = rowBytes * 8 + 12;
	localparam int frameCycles = rows * rowCycles + 16;
	localparam int cycleLimit = 2 * frameCycles * 4 + 5000;
	localparam logic [11:0] selfAddr = 12'h010;
	localparam logic [11:0] fbufAddr = 12'h020;
	localparam logic [31:0] ctrlAddr = 32'h0000_0100;
	localparam logic [31:0] statAddr = 32'h0000_0108;	// Bit 3 picks status
	localparam logic [4:0] opRd = 5'(1 << opmRead);
	localparam logic [4:0] opWr = 5'(1 << opmWrite);

	logic        clock;
	logic        arstN;
	logic        camPclk;
	logic        camHsync;
	logic        camVsync;
	logic [7:0]  camData;
	logic [63:0] mmioInData;
	logic [31:0] mmioAddr;
	logic [4:0]  mmioOpm;
	logic [11:0] mmioSelfAddr;
	logic [11:0] mmioFbufAddr;
	logic [63:0] mmioOutData;
	mmioOkT      mmioOk;
	logic        reqActive;
	logic [31:0] reqSeq;
	mmioOkT      expOk;
	logic [63:0] expData;
	logic        expHold;
	int          checkCount;
	int          errCount;
	int          cycleCount;
	int          framesSent;
	int          testNum;
	int          lastChecks;
	int          lastErrs;
	int          seedValue;
	logic [7:0]  img [0:rows-1][0:rowBytes-1];

	camCpiCapture
	#(
		.rowFirst (rowFirst),
		.rowLast  (rowLast)
	)
	camCpiCapture_inst
	(
		.clock        (clock),
		.arstN        (arstN),
		.camPclk      (camPclk),
		.camHsync     (camHsync),
		.camVsync     (camVsync),
		.camData      (camData),
		.mmioInData   (mmioInData),
		.mmioAddr     (mmioAddr),
		.mmioOpm      (mmioOpm),
		.mmioSelfAddr (mmioSelfAddr),
		.mmioFbufAddr (mmioFbufAddr),
		.mmioOutData  (mmioOutData),
		.mmioOk       (mmioOk)
	);

	camCpiChecker respChecker
	(
		.clock       (clock),
		.arstN       (arstN),
		.mmioOk      (mmioOk),
		.mmioOutData (mmioOutData),
		.reqActive   (reqActive),
		.reqSeq      (reqSeq),
		.expOk       (expOk),
		.expData     (expData),
		.expHold     (expHold),
		.checkCount  (checkCount),
		.errCount    (errCount)
	);

	always #50 clock = ~clock;

	always @(posedge clock)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout, the run did not finish within %0d cycles", cycleLimit);
			$display("Verification failed");
			$finish;
		end
	end

	// First kept pixel lands in the top nibble
	function automatic fbWordT refWord(input int idx);
		fbWordT word;
		int kept;
		word = '0;
		kept = 0;
		for (int r = 0; r < rows; r++)
			for (int b = 0; b < rowBytes; b++)
				if ((r >= rowFirst) && (r <= rowLast) && (r % 2 == 0) &&
					(b % `CAM_BYTE_DECIM == 0))
				begin
					if (kept / 16 == idx)
						word[63 - 4 * (kept % 16) -: 4] = img[r][b][7:4];
					kept++;
				end
		return word;
	endfunction

	function automatic logic [63:0] statusWord(input int frames, input int idx);
		return {32'h0, 16'(frames), 4'h0, 12'(idx)};
	endfunction

	function automatic logic [31:0] fbAddr(input int idx);
		return {4'h0, fbufAddr, 1'b0, 12'(idx), 3'b000};
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge clock);
		#driveDelay;
	endtask

	task automatic busAccess(input logic [31:0] addr, input logic [4:0] opm,
		input logic [63:0] wdata, input mmioOkT okWant, input logic [63:0] dataWant,
		input logic holdWant);
		int age;
		logic done;
		tick(1);
		mmioAddr = addr;
		mmioOpm = opm;
		mmioInData = wdata;
		expOk = okWant;
		expData = dataWant;
		expHold = holdWant;
		reqActive = 1'b1;
		reqSeq = reqSeq + 1;
		age = 0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge clock);
			age++;
			if ((age >= 3) && (mmioOk != HOLD))
				done = 1'b1;
		end
	endtask

	task automatic busIdle();
		tick(1);
		mmioOpm = '0;
		reqActive = 1'b0;
	endtask

	task automatic sendFrame();
		for (int r = 0; r < rows; r++)
			for (int b = 0; b < rowBytes; b++)
				img[r][b] = 8'($urandom());
		camVsync = 1'b1;
		tick(8);
		camVsync = 1'b0;	// Frame starts on the falling edge
		tick(8);
		for (int r = 0; r < rows; r++)
		begin
			camHsync = 1'b1;
			for (int b = 0; b < rowBytes; b++)
			begin
				camData = img[r][b];
				camPclk = 1'b0;
				tick(4);
				camPclk = 1'b1;
				tick(4);
			end
			camPclk = 1'b0;
			tick(4);
			camHsync = 1'b0;
			tick(8);
		end
		framesSent++;
	endtask

	task automatic endTest(input string name);
		@(posedge clock);
		testNum++;
		$display("Test %0d %s: %0d checks, %0d errors", testNum, name,
			checkCount - lastChecks, errCount - lastErrs);
		lastChecks = checkCount;
		lastErrs = errCount;
		#driveDelay;
	endtask

	task automatic readAllWords();
		for (int i = 0; i < keptWords; i++)
			busAccess(fbAddr(i), opRd, '0, OK, refWord(i), 1'b1);
	endtask

	initial
	begin
		clock = 1'b0;
		arstN = 1'b0;
		camPclk = 1'b0;
		camHsync = 1'b0;
		camVsync = 1'b0;
		camData = '0;
		mmioInData = '0;
		mmioAddr = '0;
		mmioOpm = '0;
		mmioSelfAddr = selfAddr;
		mmioFbufAddr = fbufAddr;
		reqActive = 1'b0;
		reqSeq = '0;
		expOk = READY;
		expData = '0;
		expHold = 1'b0;
		cycleCount = 0;
		framesSent = 0;
		testNum = 0;
		lastChecks = 0;
		lastErrs = 0;
		seedValue = 32'h229ee5ed;
		void'($urandom(seedValue));
		repeat (3) @(posedge clock);
		#driveDelay;
		arstN = 1'b1;

		busAccess(32'h0, 5'b0, '0, READY, '0, 1'b0);
		busAccess(ctrlAddr, opRd, '0, OK, '0, 1'b0);
		busIdle();
		sendFrame();
		busAccess(statAddr, opRd, '0, OK, statusWord(framesSent, 0), 1'b0);
		endTest("reset state and disabled capture");

		busAccess(ctrlAddr, opWr, 64'h1, OK, '0, 1'b0);
		busAccess(ctrlAddr, opRd, '0, OK, 64'h1, 1'b0);
		busIdle();
		sendFrame();
		readAllWords();
		endTest("first captured frame");

		busAccess(statAddr, opRd, '0, OK, statusWord(framesSent, keptWords), 1'b0);
		endTest("status after capture");

		for (int i = 0; i < keptWords; i++)
			busAccess(fbAddr((i * 5 + 5) % 8), opRd, '0, OK, refWord((i * 5 + 5) % 8), 1'b1);
		busAccess(statAddr, opRd, '0, OK, statusWord(framesSent, keptWords), 1'b0);
		busAccess(fbAddr(0), opRd, '0, OK, refWord(0), 1'b1);	// Same index after a status read
		endTest("hold before ok on changed index");

		busIdle();
		sendFrame();
		readAllWords();
		busAccess(statAddr, opRd, '0, OK, statusWord(framesSent, keptWords), 1'b0);
		endTest("second frame overwrites");

		busAccess(32'h0005_0100, opRd, '0, READY, '0, 1'b0);	// Self offset with upper bits set
		busAccess(32'h0000_0200, opRd, '0, READY, '0, 1'b0);
		busAccess(32'h0005_0000, opWr, 64'hffff, READY, '0, 1'b0);
		busAccess(fbAddr(0), opWr, 64'hffff, READY, '0, 1'b0);
		busAccess(fbAddr(0), opRd, '0, OK, refWord(0), 1'b1);
		endTest("accesses outside both regions");

		busIdle();
		@(posedge clock);
		$display("Tests %0d, checks %0d, errors %0d", testNum, checkCount, errCount);
		if ((errCount == 0) && (checkCount > 0))
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/camCpiChecker.sv
`timescale 1ns/1ns
`default_nettype none

module camCpiChecker
	import camCpiPkg::*;
(
	input wire         clock,
	input wire         arstN,
	input wire mmioOkT mmioOk,
	input wire [63:0]  mmioOutData,
	input wire         reqActive,
	input wire [31:0]  reqSeq,
	input wire mmioOkT expOk,
	input wire [63:0]  expData,
	input wire         expHold,
	output int         checkCount,
	output int         errCount
);

	logic [31:0] lastSeq;
	int          age;	// Falling edges since the request appeared
	logic        sawHold;
	logic        handled;

	// Falling edge sampling keeps clear of the DUT's register updates
	always @(negedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			lastSeq = '0;
			age = 0;
			sawHold = 1'b0;
			handled = 1'b0;
			checkCount = 0;
			errCount = 0;
		end
		else
		begin
			if (reqSeq != lastSeq)
			begin
				lastSeq = reqSeq;
				age = 1;
				sawHold = 1'b0;
				handled = 1'b0;
			end
			else
				age = age + 1;
			// Responses before the third edge still belong to the previous request
			if (reqActive && !handled && (age >= 3))
			begin
				if ((mmioOk == HOLD) && expHold)
					sawHold = 1'b1;
				else
				begin
					handled = 1'b1;
					checkCount = checkCount + 1;
					if (mmioOk != expOk)
					begin
						$display("ERR mmioOk expected %h actual %h", expOk, mmioOk);
						errCount = errCount + 1;
					end
					else if (mmioOutData != expData)
					begin
						$display("ERR mmioOutData expected %h actual %h", expData, mmioOutData);
						errCount = errCount + 1;
					end
					else if (expHold && !sawHold)
					begin
						$display("Framebuffer read answered OK without a HOLD first");
						errCount = errCount + 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: source/camCpiCapture.sv
`timescale 1ns/1ns
`default_nettype none

`include "camCpi_cfg.svh"

module camCpiCapture
	import camCpiPkg::*;
#(
	parameter int rowFirst = `CAM_ROW_FIRST,
	parameter int rowLast  = `CAM_ROW_LAST
)
(
	input wire          clock,
	input wire          arstN,
	input wire          camPclk,
	input wire          camHsync,
	input wire          camVsync,
	input wire  [7:0]   camData,
	input wire  [63:0]  mmioInData,
	input wire  [31:0]  mmioAddr,
	input wire  [4:0]   mmioOpm,
	input wire  [11:0]  mmioSelfAddr,
	input wire  [11:0]  mmioFbufAddr,
	output logic [63:0] mmioOutData,
	output mmioOkT      mmioOk
);

	logic                     byteStrobe;
	logic [7:0]               pixByte;
	logic                     rowEnd;
	logic                     frameStart;
	logic                     captureEn;
	logic                     pixelTake;
	logic [3:0]               pixNibble;
	logic                     frameRestart;
	logic                     fbWe;
	logic [`CAM_FB_IDX_W-1:0] fbWrIdx;
	fbWordT                   fbWrData;
	logic [`CAM_FB_IDX_W-1:0] wrIdx;
	logic [`CAM_FB_IDX_W-1:0] fbRdIdx;
	fbWordT                   fbRdData;

	cpiSampler cpiSampler_inst
	(
		.clock      (clock),
		.arstN      (arstN),
		.camPclk    (camPclk),
		.camHsync   (camHsync),
		.camVsync   (camVsync),
		.camData    (camData),
		.byteStrobe (byteStrobe),
		.pixByte    (pixByte),
		.rowEnd     (rowEnd),
		.frameStart (frameStart)
	);

	cpiLineGate
	#(
		.rowFirst (rowFirst),
		.rowLast  (rowLast)
	)
	cpiLineGate_inst
	(
		.clock        (clock),
		.arstN        (arstN),
		.byteStrobe   (byteStrobe),
		.pixByte      (pixByte),
		.rowEnd       (rowEnd),
		.frameStart   (frameStart),
		.captureEn    (captureEn),
		.pixelTake    (pixelTake),
		.pixNibble    (pixNibble),
		.frameRestart (frameRestart)
	);

	fbPacker fbPacker_inst
	(
		.clock        (clock),
		.arstN        (arstN),
		.pixelTake    (pixelTake),
		.pixNibble    (pixNibble),
		.frameRestart (frameRestart),
		.fbWe         (fbWe),
		.fbWrIdx      (fbWrIdx),
		.fbWrData     (fbWrData),
		.wrIdx        (wrIdx)
	);

	fbRam fbRam_inst
	(
		.clock    (clock),
		.fbWe     (fbWe),
		.fbWrIdx  (fbWrIdx),
		.fbWrData (fbWrData),
		.fbRdIdx  (fbRdIdx),
		.fbRdData (fbRdData)
	);

	mmioCamPort mmioCamPort_inst
	(
		.clock        (clock),
		.arstN        (arstN),
		.mmioInData   (mmioInData),
		.mmioAddr     (mmioAddr),
		.mmioOpm      (mmioOpm),
		.mmioSelfAddr (mmioSelfAddr),
		.mmioFbufAddr (mmioFbufAddr),
		.fbRdData     (fbRdData),
		.frameStart   (frameStart),
		.wrIdx        (wrIdx),
		.mmioOutData  (mmioOutData),
		.mmioOk       (mmioOk),
		.fbRdIdx      (fbRdIdx),
		.captureEn    (captureEn)
	);

endmodule

`default_nettype wire

// File: source/mmioCamPort.sv
`timescale 1ns/1ns
`default_nettype none

`include "camCpi_cfg.svh"

module mmioCamPort
	import camCpiPkg::*;
(
	input wire                       clock,
	input wire                       arstN,
	input wire  [63:0]               mmioInData,
	input wire  [31:0]               mmioAddr,
	input wire  [4:0]                mmioOpm,
	input wire  [11:0]               mmioSelfAddr,
	input wire  [11:0]               mmioFbufAddr,
	input wire fbWordT               fbRdData,
	input wire                       frameStart,
	input wire  [`CAM_FB_IDX_W-1:0]  wrIdx,
	output logic [63:0]              mmioOutData,
	output mmioOkT                   mmioOk,
	output logic [`CAM_FB_IDX_W-1:0] fbRdIdx,
	output logic                     captureEn
);

	localparam int idxW = `CAM_FB_IDX_W;

	logic [31:0]     regInData;	// Only the control register takes write data
	logic [31:0]     regAddr;
	logic [4:0]      regOpm;
	logic [31:0]     ctrlReg;
	logic [15:0]     frameCount;
	logic [idxW-1:0] idxLatched;	// Index behind fbRdData
	logic            fbRdLive;
	logic            selfSel;
	logic            fbSel;
	logic            fbRead;
	logic            fbMatch;
	logic [63:0]     statWord;
	logic [63:0]     nextData;
	mmioOkT          nextOk;

	assign selfSel   = (regAddr[27:16] == 12'h000) && (regAddr[15:4] == mmioSelfAddr);
	assign fbSel     = (regAddr[27:16] == mmioFbufAddr);
	assign fbRead    = fbSel && !selfSel && regOpm[opmRead];
	assign fbRdIdx   = regAddr[14:3];
	assign fbMatch   = fbRdLive && (idxLatched == fbRdIdx);
	assign captureEn = ctrlReg[0];
	assign statWord  = {32'h0, frameCount, {(16 - idxW){1'b0}}, wrIdx};

	always_comb
	begin
		nextOk   = READY;
		nextData = '0;
		if (selfSel && (regOpm[opmRead] || regOpm[opmWrite]))
		begin
			nextOk = OK;
			if (regOpm[opmRead])
				nextData = (regAddr[3] == statOffs) ? statWord : {32'h0, ctrlReg};
		end
		else if (fbRead)
		begin
			nextOk = fbMatch ? OK : HOLD;
			if (fbMatch)
				nextData = fbRdData;
		end
	end

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			regAddr     <= '0;
			regOpm      <= '0;
			ctrlReg     <= '0;
			frameCount  <= '0;
			idxLatched  <= '0;
			fbRdLive    <= 1'b0;
			mmioOk      <= READY;
			mmioOutData <= '0;
		end
		else
		begin
			regAddr     <= mmioAddr;
			regOpm      <= mmioOpm;
			idxLatched  <= fbRdIdx;
			fbRdLive    <= fbRead;	// Stale index from another access never matches
			mmioOk      <= nextOk;
			mmioOutData <= nextData;
			if (frameStart)
				frameCount <= frameCount + 1'b1;
			if (selfSel && regOpm[opmWrite] && (regAddr[3] == ctrlOffs))
				ctrlReg <= regInData;
		end
	end

	always_ff @(posedge clock)
	begin
		regInData <= mmioInData[31:0];
	end

endmodule

`default_nettype wire

// File: source/fbRam.sv
`timescale 1ns/1ns
`default_nettype none

`include "camCpi_cfg.svh"

module fbRam
	import camCpiPkg::*;
(
	input wire                       clock,
	input wire                       fbWe,
	input wire [`CAM_FB_IDX_W-1:0]   fbWrIdx,
	input wire fbWordT               fbWrData,
	input wire [`CAM_FB_IDX_W-1:0]   fbRdIdx,
	output fbWordT                   fbRdData
);

	fbWordT fbMem [0:`CAM_FB_DEPTH-1];

	// Same-index write and read returns the old word
	always_ff @(posedge clock)
	begin
		if (fbWe)
			fbMem[fbWrIdx] <= fbWrData;
		fbRdData <= fbMem[fbRdIdx];
	end

endmodule

`default_nettype wire

// File: source/fbPacker.sv
`timescale 1ns/1ns
`default_nettype none

`include "camCpi_cfg.svh"

module fbPacker
	import camCpiPkg::*;
(
	input wire                         clock,
	input wire                         arstN,
	input wire                         pixelTake,
	input wire  [3:0]                  pixNibble,
	input wire                         frameRestart,
	output logic                       fbWe,
	output logic [`CAM_FB_IDX_W-1:0]   fbWrIdx,
	output fbWordT                     fbWrData,
	output logic [`CAM_FB_IDX_W-1:0]   wrIdx
);

	localparam int idxW = `CAM_FB_IDX_W;

	logic [59:0]     partWord;	// First fifteen nibbles of a word
	logic [3:0]      nibCount;
	logic            wordDone;
	logic [idxW-1:0] nextIdx;

	assign wordDone = pixelTake && (nibCount == 4'd15);
	assign nextIdx  = (wrIdx == idxW'(`CAM_FB_DEPTH - 1)) ? '0 : wrIdx + 1'b1;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			nibCount <= '0;
			wrIdx    <= '0;
			fbWe     <= 1'b0;
		end
		else
		begin
			fbWe <= 1'b0;
			if (frameRestart)
			begin
				nibCount <= '0;	// Partial word is dropped
				wrIdx    <= '0;
			end
			else if (pixelTake)
			begin
				nibCount <= nibCount + 1'b1;
				if (wordDone)
				begin
					fbWe  <= 1'b1;
					wrIdx <= nextIdx;
				end
			end
		end
	end

	always_ff @(posedge clock)
	begin
		if (pixelTake)
			partWord <= {partWord[55:0], pixNibble};	// Oldest nibble ends up on top
		if (wordDone)
		begin
			fbWrData <= {partWord, pixNibble};
			fbWrIdx  <= wrIdx;
		end
	end

endmodule

`default_nettype wire

// File: source/cpiLineGate.sv
`timescale 1ns/1ns
`default_nettype none

`include "camCpi_cfg.svh"

module cpiLineGate
#(
	parameter int rowFirst  = `CAM_ROW_FIRST,
	parameter int rowLast   = `CAM_ROW_LAST,
	parameter int byteDecim = `CAM_BYTE_DECIM
)
(
	input wire         clock,
	input wire         arstN,
	input wire         byteStrobe,
	input wire  [7:0]  pixByte,
	input wire         rowEnd,
	input wire         frameStart,
	input wire         captureEn,
	output logic       pixelTake,
	output logic [3:0] pixNibble,
	output logic       frameRestart
);

	localparam int rowW   = $clog2(rowLast + 2);
	localparam int phaseW = $clog2(byteDecim) + 1;

	logic [rowW-1:0]   rowCount;
	logic              rowOdd;
	logic [phaseW-1:0] byteCount;	// Byte position modulo byteDecim
	logic              inWindow;

	assign inWindow = (rowCount >= rowW'(rowFirst)) && (rowCount <= rowW'(rowLast));

	assign pixelTake    = byteStrobe && captureEn && !rowOdd && inWindow && (byteCount == '0);
	assign pixNibble    = pixByte[7:4];
	assign frameRestart = frameStart;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			rowCount  <= '0;
			rowOdd    <= 1'b0;
			byteCount <= '0;
		end
		else if (frameStart)
		begin
			rowCount  <= '0;
			rowOdd    <= 1'b0;
			byteCount <= '0;
		end
		else if (rowEnd)
		begin
			byteCount <= '0;
			rowOdd    <= ~rowOdd;
			if (rowCount != '1)
				rowCount <= rowCount + 1'b1;	// Saturates past the window
		end
		else if (byteStrobe)
		begin
			if (byteCount == phaseW'(byteDecim - 1))
				byteCount <= '0;
			else
				byteCount <= byteCount + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: source/cpiSampler.sv
`timescale 1ns/1ns
`default_nettype none

module cpiSampler
(
	input wire         clock,
	input wire         arstN,
	input wire         camPclk,
	input wire         camHsync,
	input wire         camVsync,
	input wire  [7:0]  camData,
	output logic       byteStrobe,
	output logic [7:0] pixByte,
	output logic       rowEnd,
	output logic       frameStart
);

	logic [2:0] pinMeta;	// {vsync, hsync, pclk}
	logic [2:0] pinSync;
	logic [2:0] pinPrev;
	logic [7:0] dataMeta;
	logic [7:0] dataSync;

	always_ff @(posedge clock or negedge arstN)
	begin
		if (!arstN)
		begin
			pinMeta    <= '0;
			pinSync    <= '0;
			pinPrev    <= '0;
			byteStrobe <= 1'b0;
			rowEnd     <= 1'b0;
			frameStart <= 1'b0;
		end
		else
		begin
			pinMeta    <= {camVsync, camHsync, camPclk};
			pinSync    <= pinMeta;
			pinPrev    <= pinSync;
			byteStrobe <= pinSync[0] & ~pinPrev[0];	// Rising pclk
			rowEnd     <= ~pinSync[1] & pinPrev[1];	// Falling hsync
			frameStart <= ~pinSync[2] & pinPrev[2];	// Falling vsync
		end
	end

	// Data runs through the same depth so it lines up with byteStrobe
	always_ff @(posedge clock)
	begin
		dataMeta <= camData;
		dataSync <= dataMeta;
		pixByte  <= dataSync;
	end

endmodule

`default_nettype wire

// File: source/camCpiPkg.sv
`default_nettype none

package camCpiPkg;

	typedef enum logic [1:0]
	{
		READY = 2'b00,	// Idle or not selected
		OK    = 2'b01,
		HOLD  = 2'b10,	// Still being served
		FAIL  = 2'b11
	} mmioOkT;

	typedef logic [63:0] fbWordT;	// Sixteen 4-bit pixels

	// Bit positions in the 5-bit operation code
	localparam int opmRead  = 3;
	localparam int opmWrite = 4;

	// Address bit 3 inside the self block
	localparam logic ctrlOffs = 1'b0;
	localparam logic statOffs = 1'b1;

endpackage

`default_nettype wire

// File: include/camCpi_cfg.svh
`ifndef CAMCPI_CFG_SVH
`define CAMCPI_CFG_SVH

// Framebuffer depth in 64-bit words and index width
`define CAM_FB_DEPTH 4096
`define CAM_FB_IDX_W 12

// Inclusive row window counted from vsync
`define CAM_ROW_FIRST 40
`define CAM_ROW_LAST 240

// Keep one byte in this many
`define CAM_BYTE_DECIM 4

`endif
